//--- verilog/sdhc_pkg.sv
`default_nettype none

package sdhc_pkg;

	// bus geometry
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	// register index is byte address bits 7:2
	localparam int REG_IDX_W = 6;

	// register map
	localparam logic [REG_IDX_W-1:0] REG_ARG2    = 6'h00;
	localparam logic [REG_IDX_W-1:0] REG_BLK     = 6'h01;
	localparam logic [REG_IDX_W-1:0] REG_ARG1    = 6'h02;
	localparam logic [REG_IDX_W-1:0] REG_CMD     = 6'h03;
	localparam logic [REG_IDX_W-1:0] REG_RESP0   = 6'h04;
	localparam logic [REG_IDX_W-1:0] REG_RESP1   = 6'h05;
	localparam logic [REG_IDX_W-1:0] REG_RESP2   = 6'h06;
	localparam logic [REG_IDX_W-1:0] REG_RESP3   = 6'h07;
	localparam logic [REG_IDX_W-1:0] REG_PSTATE  = 6'h09;
	localparam logic [REG_IDX_W-1:0] REG_HOSTCTL = 6'h0A;
	localparam logic [REG_IDX_W-1:0] REG_CLKCTL  = 6'h0B;
	localparam logic [REG_IDX_W-1:0] REG_INTSTAT = 6'h0C;
	localparam logic [REG_IDX_W-1:0] REG_INTEN   = 6'h0D;
	localparam logic [REG_IDX_W-1:0] REG_SIGEN   = 6'h0E;
	localparam logic [REG_IDX_W-1:0] REG_ACMDERR = 6'h0F;
	localparam logic [REG_IDX_W-1:0] REG_CAP0    = 6'h10;
	localparam logic [REG_IDX_W-1:0] REG_CAP1    = 6'h11;
	// version sits at byte address FC
	localparam logic [REG_IDX_W-1:0] REG_VERSION = 6'h3F;

	// fixed read values
	localparam logic [DATA_W-1:0] CAP0_WORD    = 32'h012C_32B2;
	localparam logic [DATA_W-1:0] CAP1_WORD    = 32'h0000_0005;
	localparam logic [DATA_W-1:0] VERSION_WORD = 32'h0002_0000;

	// command path
	localparam int CMD_W = 14;
	// CMD23 index with response and crc/index checks
	localparam logic [CMD_W-1:0] ACMD23_CMD_WORD = 14'h171A;
	localparam logic [15:0] ACMD23_OK_RESP = 16'h0900;
	localparam logic [1:0] ACMD23_MODE = 2'b10;
	// only the upper half word write starts a command
	localparam logic [STRB_W-1:0] START_STRB = 4'b1100;

	// interrupt status layout
	localparam int INT_W = 29;
	localparam int INT_CC    = 0;
	localparam int INT_TC    = 1;
	localparam int INT_CTE   = 16;
	localparam int INT_CCRCE = 17;
	localparam int INT_CEBE  = 18;
	localparam int INT_CIE   = 19;
	localparam int INT_DTE   = 20;
	localparam int INT_DCRCE = 21;
	localparam int INT_DEBE  = 22;
	localparam int INT_ACMD  = 24;

	// controller side interrupt vectors
	localparam int CMD_INT_W = 5;
	localparam int DAT_INT_W = 5;

	typedef struct packed {
		logic [REG_IDX_W-1:0] idx;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
	} reg_wr_t;

	typedef struct packed {
		logic start;
		logic [CMD_W-1:0] cmd;
		logic [DATA_W-1:0] arg;
	} cmd_req_t;

	typedef struct packed {
		logic [CMD_INT_W-1:0] cmd_int;
		logic [DAT_INT_W-1:0] dat_int;
		logic cc_pulse;
	} ctrl_evt_t;

	typedef struct packed {
		logic cmd_inh;
		logic dat_inh;
		logic dat_line_act;
		logic rd_active;
		logic wr_active;
		logic clk_stable;
	} pstate_in_t;

	// byte lane merge of a strobed write
	function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
		input logic [DATA_W-1:0] new_w, input logic [STRB_W-1:0] strb);
		logic [DATA_W-1:0] res;
		res = old_w;
		for (int i = 0; i < STRB_W; i++)
		begin
			if (strb[i])
				res[8*i +: 8] = new_w[8*i +: 8];
		end
		return res;
	endfunction

endpackage

`default_nettype wire

//--- verilog/axil_reg_port.sv
`default_nettype none

module axil_reg_port
(
	input  wire S_AXI_ACLK,
	input  wire S_AXI_ARESETN,
	input  wire [sdhc_pkg::REG_IDX_W+1:0] S_AXI_AWADDR,
	input  wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input  wire [sdhc_pkg::DATA_W-1:0] S_AXI_WDATA,
	input  wire [sdhc_pkg::STRB_W-1:0] S_AXI_WSTRB,
	input  wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input  wire S_AXI_BREADY,
	input  wire [sdhc_pkg::REG_IDX_W+1:0] S_AXI_ARADDR,
	input  wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [sdhc_pkg::DATA_W-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input  wire S_AXI_RREADY,
	output sdhc_pkg::reg_wr_t wr_o,
	output logic wr_en_o,
	output logic [sdhc_pkg::REG_IDX_W-1:0] rd_idx_o,
	input  wire [sdhc_pkg::DATA_W-1:0] rd_data_i
);
	import sdhc_pkg::*;

	logic wr_rdy_q;
	logic b_valid_q;
	logic ar_rdy_q;
	logic r_valid_q;
	reg_wr_t wr_q;
	logic [REG_IDX_W-1:0] rd_idx_q;
	logic [DATA_W-1:0] r_data_q;
	logic wr_take;
	logic rd_take;

	// address and data must arrive together, one write in flight
	assign wr_take = S_AXI_AWVALID && S_AXI_WVALID && !wr_rdy_q && !b_valid_q;
	// no new read while one is still pending or held
	assign rd_take = S_AXI_ARVALID && !ar_rdy_q && !r_valid_q;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_rdy_q <= 1'b0;
			b_valid_q <= 1'b0;
			ar_rdy_q <= 1'b0;
			r_valid_q <= 1'b0;
		end
		else
		begin
			// ready pulses last one cycle
			wr_rdy_q <= wr_take;
			ar_rdy_q <= rd_take;
			// response follows the ready cycle, held until taken
			if (wr_rdy_q)
				b_valid_q <= 1'b1;
			else if (S_AXI_BREADY)
				b_valid_q <= 1'b0;
			if (ar_rdy_q)
				r_valid_q <= 1'b1;
			else if (S_AXI_RREADY)
				r_valid_q <= 1'b0;
		end
	end

	// latched address, data and read word
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (wr_take)
			wr_q <= '{idx: S_AXI_AWADDR[REG_IDX_W+1:2], data: S_AXI_WDATA, strb: S_AXI_WSTRB};
		if (rd_take)
			rd_idx_q <= S_AXI_ARADDR[REG_IDX_W+1:2];
		// mux output sampled in the ARREADY cycle
		if (ar_rdy_q)
			r_data_q <= rd_data_i;
	end

	assign S_AXI_AWREADY = wr_rdy_q;
	assign S_AXI_WREADY = wr_rdy_q;
	assign S_AXI_BVALID = b_valid_q;
	assign S_AXI_ARREADY = ar_rdy_q;
	assign S_AXI_RVALID = r_valid_q;
	assign S_AXI_RDATA = r_data_q;
	// every access answers OKAY
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// register side sees the write during the ready cycle
	assign wr_o = wr_q;
	assign wr_en_o = wr_rdy_q;
	assign rd_idx_o = rd_idx_q;

	// read data must not move while the master stalls
	rdata_hold_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		r_valid_q && !S_AXI_RREADY |=> $stable(S_AXI_RDATA));

endmodule

`default_nettype wire

//--- verilog/sdhc_reg_bank.sv
`default_nettype none

module sdhc_reg_bank
(
	input  wire S_AXI_ACLK,
	input  wire S_AXI_ARESETN,
	input  wire sdhc_pkg::reg_wr_t wr_i,
	input  wire wr_en_i,
	input  wire [sdhc_pkg::REG_IDX_W-1:0] rd_idx_i,
	output logic [sdhc_pkg::DATA_W-1:0] rd_data_o,
	output sdhc_pkg::cmd_req_t cmd_raw_o,
	output logic [sdhc_pkg::DATA_W-1:0] arg2_o,
	output logic [1:0] acmd_mode_o,
	output logic [11:0] blk_size_o,
	output logic [15:0] blk_count_o,
	output logic [7:0] clock_divisor_o,
	output logic [sdhc_pkg::DATA_W-1:0] timeout_o,
	output logic [1:0] software_reset_o,
	output logic bus_width_o,
	output logic bus_width_8bit_o,
	output logic dir_o,
	input  wire sdhc_pkg::pstate_in_t pstate_i,
	input  wire [3:0][sdhc_pkg::DATA_W-1:0] resp_i,
	input  wire [sdhc_pkg::INT_W-1:0] int_masked_i,
	input  wire [sdhc_pkg::INT_W-1:0] int_en_i,
	input  wire [sdhc_pkg::INT_W-1:0] sig_en_i,
	input  wire [7:0] acmd_err_stat_i,
	output logic int_rst_o,
	output logic dat_int_rst_o
);
	import sdhc_pkg::*;

	logic [DATA_W-1:0] arg2_q;
	logic [DATA_W-1:0] blk_q;
	logic [DATA_W-1:0] arg1_q;
	logic [DATA_W-1:0] cmd_q;
	logic [DATA_W-1:0] host_q;
	logic [DATA_W-1:0] clk_q;
	logic start_q;
	logic int_rst_q;
	logic cmd_inh_q;
	pstate_in_t pst_q;
	logic [DATA_W-1:0] pstate_word;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			arg2_q <= '0;
			blk_q <= '0;
			arg1_q <= '0;
			cmd_q <= '0;
			host_q <= '0;
			clk_q <= '0;
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			cmd_inh_q <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			// software reset bits only live for one cycle
			clk_q[26:24] <= 3'b000;
			// command inhibit ends when the controller drops its busy level
			if (pst_q.cmd_inh && !pstate_i.cmd_inh)
				cmd_inh_q <= 1'b0;
			if (wr_en_i)
			begin
				case (wr_i.idx)
				REG_ARG2: arg2_q <= merge_bytes(arg2_q, wr_i.data, wr_i.strb);
				REG_BLK: blk_q <= merge_bytes(blk_q, wr_i.data, wr_i.strb);
				REG_ARG1: arg1_q <= merge_bytes(arg1_q, wr_i.data, wr_i.strb);
				REG_CMD:
				begin
					cmd_q <= merge_bytes(cmd_q, wr_i.data, wr_i.strb);
					// upper half write launches the command
					if (wr_i.strb == START_STRB)
					begin
						start_q <= 1'b1;
						cmd_inh_q <= 1'b1;
					end
				end
				REG_HOSTCTL: host_q <= merge_bytes(host_q, wr_i.data, wr_i.strb);
				REG_CLKCTL: clk_q <= merge_bytes(clk_q, wr_i.data, wr_i.strb);
				// status clear itself is kept in the interrupt block
				REG_INTSTAT: int_rst_q <= 1'b1;
				default: ;
				endcase
			end
		end
	end

	// controller levels sampled once per cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		pst_q <= pstate_i;
	end

	// present state layout, lines 23:20 and 19:16 report idle data and cmd lines
	assign pstate_word = {7'b0, 1'b1, {4{~pst_q.dat_line_act}}, 4'hF, 6'b0,
		pst_q.rd_active, pst_q.wr_active, 5'b0, pst_q.dat_line_act,
		pst_q.dat_inh | pst_q.rd_active, cmd_inh_q};

	assign cmd_raw_o = '{start: start_q, cmd: cmd_q[29:16], arg: arg1_q};
	assign arg2_o = arg2_q;
	assign acmd_mode_o = cmd_q[3:2];
	assign dir_o = cmd_q[4];
	assign blk_size_o = blk_q[11:0];
	assign blk_count_o = blk_q[31:16];
	assign bus_width_o = host_q[1];
	assign bus_width_8bit_o = host_q[5];
	// sd clock runs at half the written divisor
	assign clock_divisor_o = clk_q[15:8] >> 1;
	// timeout counter limit is 2^(field+13)
	assign timeout_o = DATA_W'(1) << (clk_q[19:16] + 5'd13);
	// bit 24 resets all, 25 the cmd side, 26 the data side
	assign software_reset_o = clk_q[24] ? 2'b11 : (clk_q[25] ? 2'b01 :
		(clk_q[26] ? 2'b10 : 2'b00));
	assign int_rst_o = int_rst_q;
	assign dat_int_rst_o = int_rst_q;

	always_comb
	begin
		case (rd_idx_i)
		REG_ARG2: rd_data_o = arg2_q;
		REG_BLK: rd_data_o = blk_q;
		REG_ARG1: rd_data_o = arg1_q;
		REG_CMD: rd_data_o = cmd_q;
		REG_RESP0: rd_data_o = resp_i[0];
		REG_RESP1: rd_data_o = resp_i[1];
		REG_RESP2: rd_data_o = resp_i[2];
		REG_RESP3: rd_data_o = resp_i[3];
		REG_PSTATE: rd_data_o = pstate_word;
		REG_HOSTCTL: rd_data_o = host_q;
		// bit 1 shows the captured clock stable level
		REG_CLKCTL: rd_data_o = {clk_q[31:2], pst_q.clk_stable, clk_q[0]};
		REG_INTSTAT: rd_data_o = DATA_W'(int_masked_i);
		REG_INTEN: rd_data_o = DATA_W'(int_en_i);
		REG_SIGEN: rd_data_o = DATA_W'(sig_en_i);
		REG_ACMDERR: rd_data_o = DATA_W'(acmd_err_stat_i);
		REG_CAP0: rd_data_o = CAP0_WORD;
		REG_CAP1: rd_data_o = CAP1_WORD;
		REG_VERSION: rd_data_o = VERSION_WORD;
		default: rd_data_o = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/sdhc_int_status.sv
`default_nettype none

module sdhc_int_status
(
	input  wire S_AXI_ACLK,
	input  wire S_AXI_ARESETN,
	input  wire sdhc_pkg::reg_wr_t wr_i,
	input  wire wr_en_i,
	input  wire sdhc_pkg::ctrl_evt_t evt_i,
	input  wire cc_mask_i,
	input  wire acmd_err_i,
	output logic [sdhc_pkg::INT_W-1:0] stat_o,
	output logic [sdhc_pkg::INT_W-1:0] masked_o,
	output logic [sdhc_pkg::INT_W-1:0] en_o,
	output logic [sdhc_pkg::INT_W-1:0] sig_en_o
);
	import sdhc_pkg::*;

	logic [INT_W-1:0] stat_q;
	logic [INT_W-1:0] clr_q;
	logic [INT_W-1:0] en_q;
	logic [INT_W-1:0] sig_q;
	logic [INT_W-1:0] live;
	logic quiet;

	// controller vectors mapped onto the status layout
	always_comb
	begin
		live = '0;
		// CMD23 completion stays hidden from software
		live[INT_CC] = evt_i.cmd_int[0] & ~cc_mask_i;
		live[INT_TC] = evt_i.dat_int[0];
		live[INT_CEBE] = evt_i.cmd_int[1];
		live[INT_CTE] = evt_i.cmd_int[2];
		live[INT_CCRCE] = evt_i.cmd_int[3];
		live[INT_CIE] = evt_i.cmd_int[4];
		live[INT_DEBE] = evt_i.dat_int[1];
		live[INT_DTE] = evt_i.dat_int[2];
		live[INT_DCRCE] = evt_i.dat_int[3];
		live[INT_ACMD] = acmd_err_i;
	end

	assign quiet = ~(|evt_i.cmd_int) && ~(|evt_i.dat_int);

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			stat_q <= '0;
			clr_q <= '0;
			en_q <= '0;
			sig_q <= '0;
		end
		else
		begin
			// status is the live set minus what software cleared
			stat_q <= live & ~clr_q;
			// clear mask drops once the controller has let go
			if (quiet)
				clr_q <= '0;
			if (wr_en_i)
			begin
				case (wr_i.idx)
				REG_INTSTAT: clr_q <= INT_W'(merge_bytes(DATA_W'(clr_q), wr_i.data, wr_i.strb));
				REG_INTEN: en_q <= INT_W'(merge_bytes(DATA_W'(en_q), wr_i.data, wr_i.strb));
				REG_SIGEN: sig_q <= INT_W'(merge_bytes(DATA_W'(sig_q), wr_i.data, wr_i.strb));
				default: ;
				endcase
			end
		end
	end

	assign stat_o = stat_q;
	// software only sees enabled bits
	assign masked_o = stat_q & en_q;
	assign en_o = en_q;
	assign sig_en_o = sig_q;

endmodule

`default_nettype wire

//--- verilog/acmd23_sequencer.sv
`default_nettype none

module acmd23_sequencer
(
	input  wire S_AXI_ACLK,
	input  wire S_AXI_ARESETN,
	input  wire sdhc_pkg::cmd_req_t cmd_raw_i,
	input  wire [sdhc_pkg::DATA_W-1:0] arg2_i,
	input  wire [1:0] acmd_mode_i,
	input  wire [sdhc_pkg::DATA_W-1:0] resp0_i,
	input  wire sdhc_pkg::ctrl_evt_t evt_i,
	input  wire int_rst_i,
	output sdhc_pkg::cmd_req_t cmd_o,
	output logic cmd_int_rst_o,
	output logic cc_mask_o,
	output logic acmd_err_o,
	output logic [7:0] acmd_err_stat_o
);
	import sdhc_pkg::*;

	typedef enum logic [1:0] {S_IDLE, S_PEND, S_SEND} seq_state_t;

	seq_state_t state_q;
	logic start_q;
	logic int_rst_q;
	logic err_q;
	logic [7:0] err_stat_q;
	logic sub;

	// armed idle and the CMD23 wait both present CMD23 to the controller
	assign sub = (state_q == S_IDLE && acmd_mode_i == ACMD23_MODE) || state_q == S_PEND;

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state_q <= S_IDLE;
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			err_q <= 1'b0;
			err_stat_q <= '0;
		end
		else
		begin
			start_q <= 1'b0;
			int_rst_q <= 1'b0;
			case (state_q)
			S_IDLE:
				if (cmd_raw_i.start && acmd_mode_i == ACMD23_MODE)
					state_q <= S_PEND;
			S_PEND:
				if (evt_i.cc_pulse)
				begin
					if (resp0_i[15:0] == ACMD23_OK_RESP)
					begin
						// card accepted the block count, send the real command
						start_q <= 1'b1;
						state_q <= S_SEND;
					end
					else
					begin
						err_q <= 1'b1;
						// index, end bit, crc and timeout errors of CMD23
						err_stat_q <= {3'b000, evt_i.cmd_int[4], evt_i.cmd_int[1],
							evt_i.cmd_int[3], evt_i.cmd_int[2], 1'b0};
						state_q <= S_IDLE;
					end
				end
				else if (|evt_i.cmd_int)
					int_rst_q <= 1'b1;
			S_SEND:
				if (evt_i.cc_pulse)
					state_q <= S_IDLE;
			default: state_q <= S_IDLE;
			endcase
			// status register write acknowledges the error
			if (int_rst_i)
				err_q <= 1'b0;
		end
	end

	assign cmd_o.start = cmd_raw_i.start | start_q;
	assign cmd_o.cmd = sub ? ACMD23_CMD_WORD : cmd_raw_i.cmd;
	assign cmd_o.arg = sub ? arg2_i : cmd_raw_i.arg;
	assign cc_mask_o = sub;
	assign cmd_int_rst_o = int_rst_i | int_rst_q;
	assign acmd_err_o = err_q;
	assign acmd_err_stat_o = err_stat_q;

	// register writes and the sequencer never start back to back
	start_gap_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		cmd_o.start |=> !cmd_o.start);

endmodule

`default_nettype wire

//--- verilog/sdhc_regs_top.sv
`default_nettype none

module sdhc_regs_top
(
	input  wire S_AXI_ACLK,
	input  wire S_AXI_ARESETN,
	input  wire [sdhc_pkg::REG_IDX_W+1:0] S_AXI_AWADDR,
	input  wire S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input  wire [sdhc_pkg::DATA_W-1:0] S_AXI_WDATA,
	input  wire [sdhc_pkg::STRB_W-1:0] S_AXI_WSTRB,
	input  wire S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input  wire S_AXI_BREADY,
	input  wire [sdhc_pkg::REG_IDX_W+1:0] S_AXI_ARADDR,
	input  wire S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output logic [sdhc_pkg::DATA_W-1:0] S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input  wire S_AXI_RREADY,
	output sdhc_pkg::cmd_req_t cmd_o,
	output logic cmd_int_rst_o,
	output logic dat_int_rst_o,
	output logic [11:0] blk_size_o,
	output logic [15:0] blk_count_o,
	output logic [7:0] clock_divisor_o,
	output logic [sdhc_pkg::DATA_W-1:0] timeout_o,
	output logic [1:0] software_reset_o,
	output logic bus_width_o,
	output logic bus_width_8bit_o,
	output logic dir_o,
	input  wire sdhc_pkg::pstate_in_t pstate_i,
	input  wire [3:0][sdhc_pkg::DATA_W-1:0] resp_i,
	input  wire sdhc_pkg::ctrl_evt_t evt_i,
	output logic [sdhc_pkg::INT_W-1:0] int_stat_o,
	output logic [sdhc_pkg::INT_W-1:0] int_en_o,
	output logic [sdhc_pkg::INT_W-1:0] sig_en_o
);
	import sdhc_pkg::*;

	reg_wr_t wr;
	logic wr_en;
	logic [REG_IDX_W-1:0] rd_idx;
	logic [DATA_W-1:0] rd_data;
	cmd_req_t cmd_raw;
	logic [DATA_W-1:0] arg2;
	logic [1:0] acmd_mode;
	logic int_rst;
	logic [INT_W-1:0] int_masked;
	logic cc_mask;
	logic acmd_err;
	logic [7:0] acmd_err_stat;

	axil_reg_port u_port (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR), .S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY), .S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WSTRB(S_AXI_WSTRB), .S_AXI_WVALID(S_AXI_WVALID),
		.S_AXI_WREADY(S_AXI_WREADY), .S_AXI_BRESP(S_AXI_BRESP),
		.S_AXI_BVALID(S_AXI_BVALID), .S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR), .S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY), .S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP), .S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY), .wr_o(wr), .wr_en_o(wr_en),
		.rd_idx_o(rd_idx), .rd_data_i(rd_data));

	sdhc_reg_bank u_bank (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_i(wr), .wr_en_i(wr_en), .rd_idx_i(rd_idx), .rd_data_o(rd_data),
		.cmd_raw_o(cmd_raw), .arg2_o(arg2), .acmd_mode_o(acmd_mode),
		.blk_size_o(blk_size_o), .blk_count_o(blk_count_o),
		.clock_divisor_o(clock_divisor_o), .timeout_o(timeout_o),
		.software_reset_o(software_reset_o), .bus_width_o(bus_width_o),
		.bus_width_8bit_o(bus_width_8bit_o), .dir_o(dir_o), .pstate_i(pstate_i),
		.resp_i(resp_i), .int_masked_i(int_masked), .int_en_i(int_en_o),
		.sig_en_i(sig_en_o), .acmd_err_stat_i(acmd_err_stat),
		.int_rst_o(int_rst), .dat_int_rst_o(dat_int_rst_o));

	sdhc_int_status u_int (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.wr_i(wr), .wr_en_i(wr_en), .evt_i(evt_i), .cc_mask_i(cc_mask),
		.acmd_err_i(acmd_err), .stat_o(int_stat_o), .masked_o(int_masked),
		.en_o(int_en_o), .sig_en_o(sig_en_o));

	// CMD23 substitution sits between the register and the controller
	acmd23_sequencer u_acmd (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.cmd_raw_i(cmd_raw), .arg2_i(arg2), .acmd_mode_i(acmd_mode),
		.resp0_i(resp_i[0]), .evt_i(evt_i), .int_rst_i(int_rst), .cmd_o(cmd_o),
		.cmd_int_rst_o(cmd_int_rst_o), .cc_mask_o(cc_mask), .acmd_err_o(acmd_err),
		.acmd_err_stat_o(acmd_err_stat));

endmodule

`default_nettype wire

//--- bench/tb_sdhc_regs.sv
`default_nettype none

module tb_sdhc_regs;
	timeunit 1ns;
	timeprecision 1ps;
	import sdhc_pkg::*;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	logic [7:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic [3:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [7:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	cmd_req_t cmd;
	logic cmd_int_rst;
	logic dat_int_rst;
	logic [11:0] blk_size;
	logic [15:0] blk_count;
	logic [7:0] clock_divisor;
	logic [31:0] timeout;
	logic [1:0] software_reset;
	logic bus_width;
	logic bus_width_8bit;
	logic dir;
	pstate_in_t pst;
	logic [3:0][31:0] resp;
	ctrl_evt_t evt;
	logic [INT_W-1:0] int_stat;
	logic [INT_W-1:0] int_en;
	logic [INT_W-1:0] sig_en;

	// bookkeeping
	int err_count = 0;
	int check_count = 0;
	int test_err_base = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] lfsr_q = 32'ha4bb908b;

	// monitor counters updated after each edge
	int srst_count = 0;
	logic [1:0] srst_last = 2'b00;
	int start_count = 0;
	logic [CMD_W-1:0] start_cmd = '0;
	logic [31:0] start_arg = '0;
	int int_rst_count = 0;
	int cmd_rst_count = 0;

	sdhc_regs_top u_dut (.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(awaddr), .S_AXI_AWVALID(awvalid), .S_AXI_AWREADY(awready),
		.S_AXI_WDATA(wdata), .S_AXI_WSTRB(wstrb), .S_AXI_WVALID(wvalid),
		.S_AXI_WREADY(wready), .S_AXI_BRESP(bresp), .S_AXI_BVALID(bvalid),
		.S_AXI_BREADY(bready), .S_AXI_ARADDR(araddr), .S_AXI_ARVALID(arvalid),
		.S_AXI_ARREADY(arready), .S_AXI_RDATA(rdata), .S_AXI_RRESP(rresp),
		.S_AXI_RVALID(rvalid), .S_AXI_RREADY(rready), .cmd_o(cmd),
		.cmd_int_rst_o(cmd_int_rst), .dat_int_rst_o(dat_int_rst),
		.blk_size_o(blk_size), .blk_count_o(blk_count),
		.clock_divisor_o(clock_divisor), .timeout_o(timeout),
		.software_reset_o(software_reset), .bus_width_o(bus_width),
		.bus_width_8bit_o(bus_width_8bit), .dir_o(dir), .pstate_i(pst),
		.resp_i(resp), .evt_i(evt), .int_stat_o(int_stat), .int_en_o(int_en),
		.sig_en_o(sig_en));

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #20 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// pulse monitor
	always @(posedge S_AXI_ACLK)
	begin
		if (software_reset != 2'b00)
		begin
			srst_count <= srst_count + 1;
			srst_last <= software_reset;
		end
		if (cmd.start)
		begin
			start_count <= start_count + 1;
			start_cmd <= cmd.cmd;
			start_arg <= cmd.arg;
		end
		if (dat_int_rst)
			int_rst_count <= int_rst_count + 1;
		if (cmd_int_rst)
			cmd_rst_count <= cmd_rst_count + 1;
	end

	// software reset is a single cycle pulse
	srst_pulse_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		software_reset != 2'b00 |=> software_reset == 2'b00)
	else
	begin
		err_count++;
		$display("software reset output stayed high for more than one cycle");
	end

	// address and data channels are accepted together
	ready_pair_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		awready == wready)
	else
	begin
		err_count++;
		$display("AWREADY and WREADY were not raised together");
	end

	// status reset pulse lasts one cycle per write
	rst_pulse_a: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
		dat_int_rst |=> !dat_int_rst)
	else
	begin
		err_count++;
		$display("interrupt reset pulse lasted more than one cycle");
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_q = lfsr_step(lfsr_q);
			r = {r[30:0], lfsr_q[0]};
		end
		return r;
	endfunction

	// byte lanes with a strobe take the new data
	function automatic logic [31:0] strobe_merge(input logic [31:0] old_w,
		input logic [31:0] new_w, input logic [3:0] strb);
		logic [31:0] mask;
		mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
		return (old_w & ~mask) | (new_w & mask);
	endfunction

	// auto cmd error byte holds timeout in bit 1, crc in 2, end bit in 3 and index in 4
	function automatic logic [7:0] acmd_err_byte(input logic [CMD_INT_W-1:0] ints);
		logic [7:0] b;
		b = 8'h00;
		b[1] = ints[2];
		b[2] = ints[3];
		b[3] = ints[1];
		b[4] = ints[4];
		return b;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		assert (got === exp)
		else
		begin
			err_count++;
			$display("FAIL %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_run();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests_run, tests_failed,
			check_count, err_count);
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	task automatic timeout_abort(input string what);
		err_count++;
		$display("timed out waiting for %s", what);
		end_run();
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge S_AXI_ACLK);
	endtask

	task automatic begin_test();
		test_err_base = err_count;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (err_count == test_err_base)
			$display("test %0d %s: ok", tests_run, name);
		else
		begin
			tests_failed++;
			$display("test %0d %s: %0d errors", tests_run, name, err_count - test_err_base);
		end
	endtask

	// single write with address and data offered together
	task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		int n;
		@(posedge S_AXI_ACLK);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= 1'b1;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!awready && n < 100);
		if (!awready)
			timeout_abort("AWREADY");
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!bvalid && n < 100);
		if (!bvalid)
			timeout_abort("BVALID");
		check_value("S_AXI_BRESP", bresp, 2'b00);
	endtask

	task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
		int n;
		@(posedge S_AXI_ACLK);
		araddr <= addr;
		arvalid <= 1'b1;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!arready && n < 100);
		if (!arready)
			timeout_abort("ARREADY");
		arvalid <= 1'b0;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!rvalid && n < 100);
		if (!rvalid)
			timeout_abort("RVALID");
		data = rdata;
		check_value("S_AXI_RRESP", rresp, 2'b00);
	endtask

	// controller model drives the response word and then one complete pulse
	task automatic complete_cmd(input logic [31:0] r0, input logic [CMD_INT_W-1:0] ints);
		@(posedge S_AXI_ACLK);
		resp[0] <= r0;
		@(posedge S_AXI_ACLK);
		evt.cc_pulse <= 1'b1;
		evt.cmd_int <= ints;
		@(posedge S_AXI_ACLK);
		evt.cc_pulse <= 1'b0;
		evt.cmd_int <= '0;
	endtask

	task automatic wait_starts(input int target);
		int n;
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (start_count < target && n < 100);
		if (start_count < target)
			timeout_abort("command start pulse");
	endtask

	task automatic register_merge();
		logic [7:0] addrs [4] = '{8'h00, 8'h04, 8'h08, 8'h28};
		logic [31:0] shadow;
		logic [31:0] nw;
		logic [3:0] strb;
		logic [31:0] rd;
		logic [31:0] rw;
		begin_test();
		// everything quiet out of reset
		check_value("S_AXI_AWREADY", awready, 0);
		check_value("S_AXI_BVALID", bvalid, 0);
		check_value("S_AXI_ARREADY", arready, 0);
		check_value("S_AXI_RVALID", rvalid, 0);
		check_value("cmd_o.start", cmd.start, 0);
		check_value("software_reset_o", software_reset, 0);
		check_value("cmd_int_rst_o", cmd_int_rst, 0);
		check_value("dat_int_rst_o", dat_int_rst, 0);
		check_value("int_stat_o", int_stat, 0);
		for (int r = 0; r < 4; r++)
		begin
			for (int i = 0; i < 4; i++)
			begin
				shadow = random_bits(32);
				bus_write(addrs[i], shadow, 4'hF);
				nw = random_bits(32);
				strb = random_bits(4);
				bus_write(addrs[i], nw, strb);
				shadow = strobe_merge(shadow, nw, strb);
				bus_read(addrs[i], rd);
				check_value("S_AXI_RDATA", rd, shadow);
				if (i == 1)
				begin
					check_value("blk_size_o", blk_size, shadow[11:0]);
					check_value("blk_count_o", blk_count, shadow[31:16]);
				end
				if (i == 3)
				begin
					check_value("bus_width_o", bus_width, shadow[1]);
					check_value("bus_width_8bit_o", bus_width_8bit, shadow[5]);
				end
			end
		end
		// fixed identification words
		bus_read(8'h40, rd);
		check_value("S_AXI_RDATA", rd, CAP0_WORD);
		bus_read(8'h44, rd);
		check_value("S_AXI_RDATA", rd, CAP1_WORD);
		bus_read(8'hFC, rd);
		check_value("S_AXI_RDATA", rd, VERSION_WORD);
		// unmapped index reads zero
		bus_read(8'h20, rd);
		check_value("S_AXI_RDATA", rd, 0);
		// response words read straight through
		for (int j = 0; j < 4; j++)
		begin
			rw = random_bits(32);
			resp[j] <= rw;
			bus_read(8'h10 + 4 * j, rd);
			check_value("S_AXI_RDATA", rd, rw);
		end
		end_test("register write merge");
	endtask

	task automatic clock_control();
		logic [31:0] wd;
		logic [31:0] rd;
		logic [1:0] exp_rst [3] = '{2'b11, 2'b01, 2'b10};
		int n0;
		begin_test();
		for (int i = 0; i < 4; i++)
		begin
			// keep the reset bits out of the divisor pass
			wd = random_bits(32) & ~32'h0700_0000;
			bus_write(8'h2C, wd, 4'hF);
			check_value("clock_divisor_o", clock_divisor, wd[15:8] >> 1);
			check_value("timeout_o", timeout, 32'd1 << (wd[19:16] + 13));
			// bit 1 reads the clock stable level
			bus_read(8'h2C, rd);
			check_value("S_AXI_RDATA", rd, {wd[31:2], 1'b1, wd[0]});
		end
		// all, cmd line and data line resets in turn
		for (int k = 0; k < 3; k++)
		begin
			n0 = srst_count;
			bus_write(8'h2C, wd | (32'h1 << (24 + k)), 4'hF);
			idle_cycles(2);
			check_value("software_reset_o pulses", srst_count - n0, 1);
			check_value("software_reset_o", srst_last, exp_rst[k]);
			bus_read(8'h2C, rd);
			check_value("S_AXI_RDATA", rd & 32'h0700_0000, 0);
		end
		end_test("clock control");
	endtask

	task automatic command_start();
		logic [31:0] a1;
		logic [31:0] wd;
		logic [31:0] rd;
		int n0;
		begin_test();
		a1 = random_bits(32);
		bus_write(8'h08, a1, 4'hF);
		n0 = start_count;
		// auto CMD23 off and strobes other than the upper half
		bus_write(8'h0C, 32'h0000_0000, 4'b0011);
		wd = random_bits(32) & 32'hFFFF_FFF3;
		bus_write(8'h0C, wd, 4'b1111);
		// transfer direction is mode bit 4
		check_value("dir_o", dir, wd[4]);
		idle_cycles(2);
		check_value("cmd_o.start pulses", start_count - n0, 0);
		wd = random_bits(32);
		bus_write(8'h0C, wd, START_STRB);
		// controller goes busy right after the start
		pst.cmd_inh <= 1'b1;
		idle_cycles(2);
		check_value("cmd_o.start pulses", start_count - n0, 1);
		check_value("cmd_o.cmd", start_cmd, wd[29:16]);
		check_value("cmd_o.arg", start_arg, a1);
		bus_read(8'h24, rd);
		check_value("present state bit 0", rd[0], 1);
		pst.cmd_inh <= 1'b0;
		idle_cycles(2);
		bus_read(8'h24, rd);
		check_value("present state bit 0", rd[0], 0);
		end_test("command start");
	endtask

	task automatic interrupt_status();
		logic [31:0] rd;
		logic [31:0] sd;
		int n0;
		int n1;
		begin_test();
		n0 = int_rst_count;
		n1 = cmd_rst_count;
		idle_cycles(1);
		// transfer complete held by the controller
		evt.dat_int[0] <= 1'b1;
		idle_cycles(2);
		check_value("int_stat_o", int_stat[INT_TC], 1);
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_TC], 0);
		bus_write(8'h34, 32'h1 << INT_TC, 4'hF);
		check_value("int_en_o", int_en, 32'h1 << INT_TC);
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_TC], 1);
		// write one to clear
		bus_write(8'h30, 32'h1 << INT_TC, 4'hF);
		idle_cycles(2);
		check_value("dat_int_rst_o pulses", int_rst_count - n0, 1);
		check_value("cmd_int_rst_o pulses", cmd_rst_count - n1, 1);
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_TC], 0);
		evt.dat_int[0] <= 1'b0;
		idle_cycles(2);
		check_value("int_stat_o", int_stat[INT_TC], 0);
		// a fresh event shows again once the clear has emptied
		evt.dat_int[0] <= 1'b1;
		idle_cycles(2);
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_TC], 1);
		evt.dat_int[0] <= 1'b0;
		idle_cycles(2);
		// signal enable keeps only the status width
		sd = random_bits(32);
		bus_write(8'h38, sd, 4'hF);
		check_value("sig_en_o", sig_en, sd[INT_W-1:0]);
		bus_read(8'h38, rd);
		check_value("S_AXI_RDATA", rd, sd[INT_W-1:0]);
		end_test("interrupt status");
	endtask

	task automatic cmd23_good_response();
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] c;
		int n0;
		begin_test();
		a2 = random_bits(32);
		a1 = random_bits(32);
		bus_write(8'h00, a2, 4'hF);
		bus_write(8'h08, a1, 4'hF);
		n0 = start_count;
		// transfer mode bits 3:2 = 10 arms auto CMD23
		bus_write(8'h0C, 32'h0000_0008, 4'b0011);
		c = random_bits(32);
		bus_write(8'h0C, c, START_STRB);
		idle_cycles(2);
		check_value("cmd_o.start pulses", start_count - n0, 1);
		check_value("cmd_o.cmd", start_cmd, ACMD23_CMD_WORD);
		check_value("cmd_o.arg", start_arg, a2);
		complete_cmd(32'h0000_0900, 5'b00001);
		wait_starts(n0 + 2);
		check_value("cmd_o.cmd", start_cmd, c[29:16]);
		check_value("cmd_o.arg", start_arg, a1);
		// real command completes and the sequencer returns to idle
		complete_cmd(random_bits(32), 5'b00001);
		idle_cycles(2);
		check_value("cmd_o.start pulses", start_count - n0, 2);
		end_test("auto CMD23 good response");
	endtask

	task automatic auto_cmd_error();
		logic [31:0] rd;
		logic [31:0] bad;
		logic [31:0] err_bits;
		logic [CMD_INT_W-1:0] ints;
		int n;
		int n0;
		begin_test();
		bus_write(8'h34, 32'h1 << INT_ACMD, 4'hF);
		n0 = start_count;
		bus_write(8'h0C, random_bits(32), START_STRB);
		// bit 15 set never matches 0900
		bad = random_bits(32) | 32'h0000_8000;
		err_bits = random_bits(4);
		ints = {err_bits[3:0], 1'b1};
		complete_cmd(bad, ints);
		n = 0;
		do
		begin
			@(posedge S_AXI_ACLK);
			n++;
		end
		while (!int_stat[INT_ACMD] && n < 100);
		if (!int_stat[INT_ACMD])
			timeout_abort("auto command error status");
		idle_cycles(3);
		check_value("cmd_o.start pulses", start_count - n0, 1);
		bus_read(8'h3C, rd);
		check_value("S_AXI_RDATA", rd, acmd_err_byte(ints));
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_ACMD], 1);
		bus_write(8'h30, 32'h1 << INT_ACMD, 4'hF);
		idle_cycles(2);
		check_value("int_stat_o", int_stat[INT_ACMD], 0);
		bus_read(8'h30, rd);
		check_value("S_AXI_RDATA", rd[INT_ACMD], 0);
		end_test("auto CMD23 bad response");
	endtask

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b1;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b1;
		pst = '0;
		pst.clk_stable = 1'b1;
		resp = '0;
		evt = '0;
		repeat (8) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		idle_cycles(2);
		register_merge();
		clock_control();
		command_start();
		interrupt_status();
		cmd23_good_response();
		auto_cmd_error();
		end_run();
	end

endmodule

`default_nettype wire

//--- sim.f
verilog/sdhc_pkg.sv
verilog/axil_reg_port.sv
verilog/sdhc_reg_bank.sv
verilog/sdhc_int_status.sv
verilog/acmd23_sequencer.sv
verilog/sdhc_regs_top.sv
bench/tb_sdhc_regs.sv
